/* sim/cache_stimulus.txt */
// columns: op (1 = write), byte address, wstrb, wdata, expected read value
// expected is unused on writes; index 10 gets five tags, index 2a three
0 00000100 0 00000000 00000100
0 00000104 0 00000000 00000104
1 00000108 3 aabbccdd 00000000
0 00000108 0 00000000 0000ccdd
1 0000110c c 11223344 00000000
0 0000110c 0 00000000 1122110c
0 00001100 0 00000000 00001100
1 00002104 f deadbeef 00000000
0 00002104 0 00000000 deadbeef
1 00003100 1 000000a5 00000000
0 00003100 0 00000000 000031a5
0 00000108 0 00000000 0000ccdd
0 0000110c 0 00000000 1122110c
0 00002104 0 00000000 deadbeef
0 00003100 0 00000000 000031a5
1 00004108 6 a1b2c3d4 00000000
0 0000410c 0 00000000 0000410c
0 00004108 0 00000000 00b2c308
1 000002a0 f 01020304 00000000
0 000012a4 0 00000000 000012a4
0 000022a8 0 00000000 000022a8
0 000002a0 0 00000000 01020304
1 000002a0 8 ff000000 00000000
0 000002a0 0 00000000 ff020304
0 00000100 0 00000000 00000100
0 00001108 0 00000000 00001108
0 00000108 0 00000000 0000ccdd
0 00002104 0 00000000 deadbeef

/* compile.f */
+incdir+design
design/cache_pkg.sv
design/cache_sram.sv
design/cache_ways.sv
design/cache_ctrl.sv
design/cache_top.sv
sim/cache_mem_model.sv
sim/tb_cache.sv

/* Bender.yml */
package:
  name: cache

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cache_sram.sv
      - design/cache_ways.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/cache_mem_model.sv
      - sim/tb_cache.sv

/* sim/tb_cache.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"
`default_nettype none

module tb_cache;

    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT   = 200;

    logic                          clk;
    logic                          resetn;
    logic                          valid;
    cache_pkg::cpu_req_t           req;
    logic                          addr_ok;
    logic                          data_ok;
    cache_pkg::word_t              rdata;
    logic                          rd_req;
    cache_pkg::mem_rd_req_t        rd;
    logic                          rd_rdy;
    logic                          ret_valid;
    logic                          ret_last;
    cache_pkg::word_t              ret_data;
    logic                          wr_req;
    cache_pkg::mem_wr_req_t        wr;
    logic                          wr_rdy;
    int                            mem_errors;
    int                            wb_count;

    logic [31:0]                   stim [5*MAX_TESTS];   // op, addr, wstrb, wdata, expected
    int                            errors;
    int                            tests;
    bit                            timed_out;
    bit                            have_prev;
    logic [31:`CACHE_OFFSET_W]     prev_line;
    int unsigned                   rnd_init;

    cache_top cache_top_i (.*);

    cache_mem_model mem_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // drives one cpu request from a rising edge
    task automatic run_request(input int n, input logic op, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [31:0] wdata,
                               input logic [31:0] expected);
        int cycles;
        int bad_before;
        bit want_hit;
        bit saw_rd;
        bit done;
        want_hit   = have_prev && (addr[31:`CACHE_OFFSET_W] == prev_line);
        bad_before = errors + mem_errors;
        saw_rd     = 1'b0;
        done       = 1'b0;
        cycles     = 0;
        repeat ($urandom % 4) @(posedge clk);
        #2;
        valid      = 1'b1;
        req.op     = op;
        req.tag    = addr[31 -: `CACHE_TAG_W];
        req.index  = addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
        req.offset = addr[`CACHE_OFFSET_W-1:0];
        req.wstrb  = strb;
        req.wdata  = wdata;
        @(posedge clk);
        while (!addr_ok && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!addr_ok) begin
            $display("timeout: test %0d was never accepted", n);
            timed_out = 1'b1;
        end else begin
            #2;
            valid  = 1'b0;
            cycles = 0;
            while (!done && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
                saw_rd = saw_rd || rd_req;
                done   = data_ok;
            end
            if (!done) begin
                $display("timeout: test %0d never got data_ok", n);
                timed_out = 1'b1;
            end else begin
                if (!op) begin
                    assert (rdata == expected) else begin
                        $display("error rdata test %0d addr %h: expected %h got %h",
                                 n, addr, expected, rdata);
                        errors++;
                    end
                end
                if (want_hit) begin   // same line as the last access
                    assert (cycles == 1) else begin
                        $display("error data_ok latency test %0d: expected %h got %h",
                                 n, 32'h1, cycles);
                        errors++;
                    end
                    assert (!saw_rd) else begin
                        $display("test %0d should have hit but raised rd_req", n);
                        errors++;
                    end
                end
            end
        end
        have_prev = 1'b1;
        prev_line = addr[31:`CACHE_OFFSET_W];
        $display("test %0d %s %h, %0d cycles, %s", n, op ? "write" : "read ", addr, cycles,
                 (errors + mem_errors == bad_before && !timed_out) ? "ok" : "failed");
    endtask

    initial begin
        rnd_init  = $urandom(81236);
        errors    = 0;
        tests     = 0;
        timed_out = 1'b0;
        have_prev = 1'b0;
        prev_line = '0;
        resetn    = 1'b0;
        valid     = 1'b0;
        req       = '0;
        $readmemh("sim/cache_stimulus.txt", stim);
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(posedge clk);
        while (tests < MAX_TESTS && !$isunknown(stim[5*tests]) && !timed_out) begin
            run_request(tests, stim[5*tests][0], stim[5*tests+1], stim[5*tests+2][3:0],
                        stim[5*tests+3], stim[5*tests+4]);
            tests++;
        end
        assert (wb_count > 0) else begin
            $display("no dirty line was written back during the run");
            errors++;
        end
        $display("tests %0d, errors %0d, write-backs %0d", tests, errors + mem_errors,
                 wb_count);
        if (errors == 0 && mem_errors == 0 && !timed_out) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_mem_model (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire logic                   valid,
    input  wire logic                   addr_ok,
    input  wire cache_pkg::cpu_req_t    req,
    input  wire logic                   rd_req,
    input  wire cache_pkg::mem_rd_req_t rd,
    output logic                        rd_rdy,
    output logic                        ret_valid,
    output logic                        ret_last,
    output cache_pkg::word_t            ret_data,
    input  wire logic                   wr_req,
    input  wire cache_pkg::mem_wr_req_t wr,
    output logic                        wr_rdy,
    output int                          mem_errors,
    output int                          wb_count
);

    localparam int WORDS = 16384;   // low 64 KB of the address space

    cache_pkg::word_t mem    [WORDS];
    cache_pkg::word_t shadow [WORDS];   // cpu view with every store applied
    int               rd_errors;
    int               wr_errors;
    int               gap;
    logic [13:0]      rd_base;
    logic [13:0]      wr_base;
    logic [13:0]      st_word;

    assign mem_errors = rd_errors + wr_errors;

    // store snoop, write-back check and wr_rdy
    initial begin
        wr_rdy    = 1'b0;
        wr_errors = 0;
        wb_count  = 0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i]    = 32'(i * 4);
            shadow[i] = 32'(i * 4);
        end
        forever begin
            @(posedge clk);
            if (resetn && valid && addr_ok && req.op) begin
                st_word = {req.tag[3:0], req.index, req.offset[3:2]};
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) begin
                        shadow[st_word][8*b +: 8] = req.wdata[8*b +: 8];
                    end
                end
            end
            if (resetn && wr_req && wr_rdy) begin
                wb_count++;
                wr_base = wr.addr[15:2];
                assert (wr.addr[31:16] == 16'h0 && wr.addr[3:0] == 4'h0) else begin
                    $display("write-back to %h lies outside the modelled memory", wr.addr);
                    wr_errors++;
                end
                for (int b = 0; b < 4; b++) begin
                    assert (wr.data[b] == shadow[wr_base + b]) else begin
                        $display("error wr.data[%0d] at %h: expected %h got %h", b,
                                 wr.addr + 4 * b, shadow[wr_base + b], wr.data[b]);
                        wr_errors++;
                    end
                    mem[wr_base + b] = wr.data[b];
                end
            end
            #2;
            wr_rdy = ($urandom % 3) == 0;
        end
    end

    // line reads as four beats with random gaps
    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_errors = 0;
        forever begin
            @(posedge clk);
            if (resetn && rd_req && rd_rdy) begin
                rd_base = rd.addr[15:2];
                assert (rd.addr[31:16] == 16'h0 && rd.addr[3:0] == 4'h0) else begin
                    $display("line read of %h lies outside the modelled memory", rd.addr);
                    rd_errors++;
                end
                #2;
                rd_rdy = 1'b0;
                for (int b = 0; b < 4; b++) begin
                    gap       = $urandom % 3;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                    repeat (gap) begin
                        @(posedge clk);
                        #2;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (b == 3);
                    ret_data  = mem[rd_base + b];
                    @(posedge clk);
                    #2;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end else begin
                #2;
                rd_rdy = ($urandom % 3) == 0;
            end
        end
    end

endmodule

`default_nettype wire

/* design/cache_top.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"
`default_nettype none

module cache_top (
    input  wire logic                 clk,
    input  wire logic                 resetn,
    input  wire logic                 valid,
    input  wire cache_pkg::cpu_req_t  req,
    output logic                      addr_ok,
    output logic                      data_ok,
    output cache_pkg::word_t          rdata,
    output logic                      rd_req,
    output cache_pkg::mem_rd_req_t    rd,
    input  wire logic                 rd_rdy,
    input  wire logic                 ret_valid,
    input  wire logic                 ret_last,
    input  wire cache_pkg::word_t     ret_data,
    output logic                      wr_req,
    output cache_pkg::mem_wr_req_t    wr,
    input  wire logic                 wr_rdy
);

    logic [`CACHE_INDEX_W-1:0]                  ram_index;
    cache_pkg::tag_t                            req_tag;
    logic [$clog2(`CACHE_BANKS)-1:0]            word_sel;
    logic [$clog2(`CACHE_WAYS)-1:0]             victim_way;
    logic [`CACHE_WAYS-1:0]                     tag_we;
    logic [`CACHE_WAYS-1:0][`CACHE_BANKS-1:0]   bank_we;
    cache_pkg::word_t                           bank_wdata;
    logic [`CACHE_WAYS-1:0]                     dirty_we;
    logic                                       dirty_val;
    logic [`CACHE_WAYS-1:0]                     valid_set;
    logic [`CACHE_WAYS-1:0]                     hit;
    cache_pkg::word_t                           hit_word;
    cache_pkg::line_t                           victim_line;
    cache_pkg::tag_t                            victim_tag;
    logic                                       victim_dirty;

    cache_ctrl u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .wr_rdy       (wr_rdy),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_line  (victim_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd           (rd),
        .wr_req       (wr_req),
        .wr           (wr),
        .ram_index    (ram_index),
        .req_tag      (req_tag),
        .word_sel     (word_sel),
        .victim_way   (victim_way),
        .tag_we       (tag_we),
        .bank_we      (bank_we),
        .bank_wdata   (bank_wdata),
        .dirty_we     (dirty_we),
        .dirty_val    (dirty_val),
        .valid_set    (valid_set)
    );

    cache_ways u_ways (
        .clk          (clk),
        .resetn       (resetn),
        .ram_index    (ram_index),
        .req_tag      (req_tag),
        .victim_way   (victim_way),
        .tag_we       (tag_we),
        .bank_we      (bank_we),
        .bank_wdata   (bank_wdata),
        .dirty_we     (dirty_we),
        .dirty_val    (dirty_val),
        .valid_set    (valid_set),
        .word_sel     (word_sel),
        .hit          (hit),
        .hit_word     (hit_word),
        .victim_line  (victim_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

endmodule

`default_nettype wire

/* design/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"
`default_nettype none

module cache_ctrl (
    input  wire logic                                      clk,
    input  wire logic                                      resetn,
    input  wire logic                                      valid,
    input  wire cache_pkg::cpu_req_t                       req,
    input  wire logic                                      rd_rdy,
    input  wire logic                                      ret_valid,
    input  wire logic                                      ret_last,
    input  wire cache_pkg::word_t                          ret_data,
    input  wire logic                                      wr_rdy,
    input  wire logic [`CACHE_WAYS-1:0]                    hit,
    input  wire cache_pkg::word_t                          hit_word,
    input  wire cache_pkg::line_t                          victim_line,
    input  wire cache_pkg::tag_t                           victim_tag,
    input  wire logic                                      victim_dirty,
    output logic                                           addr_ok,
    output logic                                           data_ok,
    output cache_pkg::word_t                               rdata,
    output logic                                           rd_req,
    output cache_pkg::mem_rd_req_t                         rd,
    output logic                                           wr_req,
    output cache_pkg::mem_wr_req_t                         wr,
    output logic [`CACHE_INDEX_W-1:0]                      ram_index,
    output cache_pkg::tag_t                                req_tag,
    output logic [$clog2(`CACHE_BANKS)-1:0]                word_sel,
    output logic [$clog2(`CACHE_WAYS)-1:0]                 victim_way,
    output logic [`CACHE_WAYS-1:0]                         tag_we,
    output logic [`CACHE_WAYS-1:0][`CACHE_BANKS-1:0]       bank_we,
    output cache_pkg::word_t                               bank_wdata,
    output logic [`CACHE_WAYS-1:0]                         dirty_we,
    output logic                                           dirty_val,
    output logic [`CACHE_WAYS-1:0]                         valid_set
);

    // one-hot state bits
    localparam int S_IDLE    = 0;
    localparam int S_LOOKUP  = 1;
    localparam int S_MISS    = 2;
    localparam int S_REPLACE = 3;
    localparam int S_REFILL  = 4;

    logic [4:0]                          state;
    logic [4:0]                          state_nxt;
    cache_pkg::cpu_req_t                 req_q;
    logic [22:0]                         lfsr;
    logic [$clog2(`CACHE_BANKS)-1:0]     beat_cnt;
    logic [$clog2(`CACHE_BANKS)-1:0]     bank_sel;
    logic [`CACHE_WAYS-1:0]              way_onehot;
    logic                                lookup_hit;
    logic                                hit_write;
    logic                                beat_hit;
    logic                                refill_done;

    function automatic cache_pkg::word_t merge_word(input cache_pkg::word_t old_w,
                                                    input cache_pkg::word_t new_w,
                                                    input logic [3:0]       strb);
        cache_pkg::word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign bank_sel    = req_q.offset[`CACHE_OFFSET_W-1:2];
    assign way_onehot  = `CACHE_WAYS'(1) << victim_way;
    assign lookup_hit  = state[S_LOOKUP] && (|hit);
    assign hit_write   = lookup_hit && req_q.op;
    assign beat_hit    = state[S_REFILL] && ret_valid && (beat_cnt == bank_sel);
    assign refill_done = state[S_REFILL] && ret_valid && ret_last;

    // request buffer
    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= 5'b1 << S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        unique case (1'b1)
            state[S_IDLE]:    if (valid) state_nxt = 5'b1 << S_LOOKUP;
            state[S_LOOKUP]:  state_nxt = (|hit) ? 5'b1 << S_IDLE : 5'b1 << S_MISS;
            state[S_MISS]:    if (!victim_dirty || wr_rdy) state_nxt = 5'b1 << S_REPLACE;
            state[S_REPLACE]: if (rd_rdy) state_nxt = 5'b1 << S_REFILL;
            state[S_REFILL]:  if (ret_valid && ret_last) state_nxt = 5'b1 << S_IDLE;
            default:          state_nxt = 5'b1 << S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else begin
            lfsr <= {lfsr[21:0], lfsr[`CACHE_LFSR_TAP_HI] ^ lfsr[`CACHE_LFSR_TAP_LO]};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_way <= '0;
        end else if (state[S_LOOKUP] && !(|hit)) begin
            victim_way <= lfsr[$clog2(`CACHE_WAYS)-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (state[S_REPLACE] && rd_rdy) begin
            beat_cnt <= '0;
        end else if (state[S_REFILL] && ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign addr_ok = state[S_IDLE] && valid;
    assign data_ok = lookup_hit || (beat_hit && !req_q.op) || (refill_done && req_q.op);
    assign rdata   = state[S_LOOKUP] ? hit_word : ret_data;

    assign rd_req  = state[S_REPLACE];
    assign rd.addr = {req_q.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_req  = state[S_MISS] && victim_dirty;   // clean victims skip write-back
    assign wr.addr = {victim_tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr.data = victim_line;

    assign ram_index = state[S_IDLE] ? req.index : req_q.index;
    assign req_tag   = req_q.tag;
    assign word_sel  = bank_sel;

    assign tag_we    = refill_done ? way_onehot : '0;
    assign valid_set = refill_done ? way_onehot : '0;
    assign dirty_we  = hit_write ? hit : (refill_done ? way_onehot : '0);
    assign dirty_val = req_q.op;   // a read refill leaves the line clean

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            for (int b = 0; b < `CACHE_BANKS; b++) begin
                bank_we[w][b] = (hit_write && hit[w] && (bank_sel == b))
                             || (state[S_REFILL] && ret_valid && (victim_way == w)
                                 && (beat_cnt == b));
            end
        end
    end

    // store data merged over the hit word or the matching refill beat
    always_comb begin
        if (state[S_LOOKUP]) begin
            bank_wdata = merge_word(hit_word, req_q.wdata, req_q.wstrb);
        end else if (req_q.op && beat_cnt == bank_sel) begin
            bank_wdata = merge_word(ret_data, req_q.wdata, req_q.wstrb);
        end else begin
            bank_wdata = ret_data;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot(state));

    a_rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req);

    a_data_ok_state: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> (state[S_LOOKUP] || state[S_REFILL]));

endmodule

`default_nettype wire

/* design/cache_ways.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"
`default_nettype none

module cache_ways (
    input  wire logic                                      clk,
    input  wire logic                                      resetn,
    input  wire logic [`CACHE_INDEX_W-1:0]                 ram_index,
    input  wire cache_pkg::tag_t                           req_tag,
    input  wire logic [$clog2(`CACHE_WAYS)-1:0]            victim_way,
    input  wire logic [`CACHE_WAYS-1:0]                    tag_we,
    input  wire logic [`CACHE_WAYS-1:0][`CACHE_BANKS-1:0]  bank_we,
    input  wire cache_pkg::word_t                          bank_wdata,
    input  wire logic [`CACHE_WAYS-1:0]                    dirty_we,
    input  wire logic                                      dirty_val,
    input  wire logic [`CACHE_WAYS-1:0]                    valid_set,
    input  wire logic [$clog2(`CACHE_BANKS)-1:0]           word_sel,
    output logic [`CACHE_WAYS-1:0]                         hit,
    output cache_pkg::word_t                               hit_word,
    output cache_pkg::line_t                               victim_line,
    output cache_pkg::tag_t                                victim_tag,
    output logic                                           victim_dirty
);

    cache_pkg::tag_t  way_tag  [`CACHE_WAYS];
    cache_pkg::line_t way_line [`CACHE_WAYS];

    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_q;
    logic [`CACHE_INDEX_W-1:0]               idx_q;   // index of the ram read in flight

    for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
        cache_sram #(
            .payload_t (cache_pkg::tag_t),
            .DEPTH     (`CACHE_SETS)
        ) u_tag (
            .clk   (clk),
            .we    (tag_we[w]),
            .addr  (ram_index),
            .wdata (req_tag),
            .rdata (way_tag[w])
        );

        for (genvar b = 0; b < `CACHE_BANKS; b++) begin : g_bank
            cache_sram #(
                .payload_t (cache_pkg::word_t),
                .DEPTH     (`CACHE_SETS)
            ) u_bank (
                .clk   (clk),
                .we    (bank_we[w][b]),
                .addr  (ram_index),
                .wdata (bank_wdata),
                .rdata (way_line[w][b])
            );
        end

        assign hit[w] = valid_q[w][idx_q] && (way_tag[w] == req_tag);
    end

    // align flop arrays with the one-cycle ram read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            idx_q <= '0;
        end else begin
            idx_q <= ram_index;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (valid_set[w]) begin
                    valid_q[w][ram_index] <= 1'b1;
                end
                if (dirty_we[w]) begin
                    dirty_q[w][ram_index] <= dirty_val;
                end
            end
        end
    end

    assign hit_word     = hit[1] ? way_line[1][word_sel] : way_line[0][word_sel];
    assign victim_line  = way_line[victim_way];
    assign victim_tag   = way_tag[victim_way];
    assign victim_dirty = dirty_q[victim_way][idx_q];

    // refill only ever targets a way that missed
    a_single_hit: assert property (@(posedge clk) disable iff (!resetn)
        !(hit[0] && hit[1]));

endmodule

`default_nettype wire

/* design/cache_sram.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"
`default_nettype none

module cache_sram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = `CACHE_SETS
) (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr,
    input  wire payload_t                 wdata,
    output payload_t                      rdata
);

    payload_t mem [DEPTH];

    // read returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`include "cache_settings.svh"
`default_nettype none

package cache_pkg;

    typedef logic [31:0] word_t;

    typedef logic [`CACHE_TAG_W-1:0] tag_t;

    // bank 0 in the low word
    typedef word_t [`CACHE_BANKS-1:0] line_t;

    typedef struct packed {
        logic                       op;     // 1 = write
        logic [`CACHE_INDEX_W-1:0]  index;
        tag_t                       tag;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic [3:0]                 wstrb;
        word_t                      wdata;
    } cpu_req_t;

    // always a whole line
    typedef struct packed {
        logic [31:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] addr;
        line_t       data;
    } mem_wr_req_t;

endpackage

`default_nettype wire

/* design/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// geometry
`define CACHE_SETS      256
`define CACHE_INDEX_W   8
`define CACHE_TAG_W     20
`define CACHE_OFFSET_W  4
`define CACHE_BANKS     4
`define CACHE_WAYS      2

// 23-bit lfsr for victim selection
`define CACHE_LFSR_SEED   23'h5500ff
`define CACHE_LFSR_TAP_HI 22
`define CACHE_LFSR_TAP_LO 17

`endif
